// ==== hw/mesh_pkg.sv ====
// mesh network shared definitions
package mesh_pkg;

  // grid size
  localparam int NUM_X = 2;
  localparam int NUM_Y = 2;

  // one spare x value so an off-grid column can be addressed
  localparam int X_W = $clog2(NUM_X + 1);
  // io row, router rows and memory row
  localparam int Y_W = $clog2(NUM_Y + 2);

  // bank geometry and payload
  localparam int ADDR_W    = 8;
  localparam int MEM_WORDS = 256;
  localparam int DATA_W    = 32;
  localparam int TAG_W     = 4;

  typedef enum logic [1:0] {
    OP_LOAD  = 2'd0,
    OP_STORE = 2'd1,
    OP_REPLY = 2'd2
  } link_op_e;

  // router port index
  typedef enum logic [1:0] {
    PORT_N = 2'd0,
    PORT_E = 2'd1,
    PORT_S = 2'd2,
    PORT_W = 2'd3
  } port_e;

  typedef struct packed {
    link_op_e            op;
    logic [X_W-1:0]      dst_x;
    logic [Y_W-1:0]      dst_y;
    logic [X_W-1:0]      src_x;
    logic [Y_W-1:0]      src_y;
    logic [TAG_W-1:0]    tag;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
  } link_pkt_s;

endpackage

// ==== hw/mesh_router.sv ====
// four-port mesh router
`timescale 1ns/1ps

module mesh_router
  import mesh_pkg::*;
#(
  parameter int my_x = 0,
  parameter int my_y = 1
) (
  input  logic            clk,
  input  logic            reset,

  input  link_pkt_s [3:0] in_pkt_i,
  input  logic [3:0]      in_valid_i,
  output logic [3:0]      in_ready_o,

  output link_pkt_s [3:0] out_pkt_o,
  output logic [3:0]      out_valid_o,
  input  logic [3:0]      out_ready_i
);

  // input buffers
  link_pkt_s [3:0]  buf_pkt;
  logic [3:0]       buf_full;

  // head of each input, buffered or straight from the link
  link_pkt_s [3:0]  head_pkt;
  logic [3:0]       head_valid;
  port_e [3:0]      head_dir;
  logic [3:0]       head_taken;

  // req[o][i]: input i wants output o
  logic [3:0][3:0]  req;
  logic [3:0]       grant_valid;
  logic [3:0][1:0]  grant_idx;
  logic [3:0]       out_load;
  logic [3:0][1:0]  rr_ptr;

  // output stage
  link_pkt_s [3:0]  out_pkt_r;
  logic [3:0]       out_valid_r;

  // x first, then y
  function automatic port_e route_f(link_pkt_s p);
    port_e dir;
    if (int'(p.dst_x) > my_x) begin
      dir = PORT_E;
    end else if (int'(p.dst_x) < my_x) begin
      dir = PORT_W;
    end else if (int'(p.dst_y) > my_y) begin
      dir = PORT_S;
    end else begin
      dir = PORT_N;
    end
    return dir;
  endfunction

  assign in_ready_o  = ~buf_full;
  assign out_pkt_o   = out_pkt_r;
  assign out_valid_o = out_valid_r;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      head_pkt[i]   = buf_full[i] ? buf_pkt[i] : in_pkt_i[i];
      head_valid[i] = buf_full[i] | in_valid_i[i];
      head_dir[i]   = route_f(head_pkt[i]);
    end
  end

  always_comb begin
    for (int o = 0; o < 4; o++) begin
      for (int i = 0; i < 4; i++) begin
        req[o][i] = head_valid[i] && (head_dir[i] == port_e'(o));
      end
    end
  end

  // round-robin, the input at rr_ptr has first claim
  always_comb begin
    logic [1:0] idx;
    for (int o = 0; o < 4; o++) begin
      grant_valid[o] = 1'b0;
      grant_idx[o]   = rr_ptr[o];
      for (int k = 3; k >= 0; k--) begin
        idx = rr_ptr[o] + 2'(k);
        if (req[o][idx]) begin
          grant_valid[o] = 1'b1;
          grant_idx[o]   = idx;
        end
      end
      out_load[o] = grant_valid[o] && (!out_valid_r[o] || out_ready_i[o]);
    end
  end

  always_comb begin
    head_taken = '0;
    for (int o = 0; o < 4; o++) begin
      if (out_load[o]) begin
        head_taken[grant_idx[o]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      buf_full    <= '0;
      out_valid_r <= '0;
      rr_ptr      <= '0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (buf_full[i]) begin
          if (head_taken[i]) begin
            buf_full[i] <= 1'b0;
          end
        end else if (in_valid_i[i] && !head_taken[i]) begin
          // blocked this cycle, park it
          buf_full[i] <= 1'b1;
        end
      end
      for (int o = 0; o < 4; o++) begin
        if (out_load[o]) begin
          out_valid_r[o] <= 1'b1;
          rr_ptr[o]      <= grant_idx[o] + 2'd1;
        end else if (out_ready_i[o]) begin
          out_valid_r[o] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (!buf_full[i] && in_valid_i[i]) begin
        buf_pkt[i] <= in_pkt_i[i];
      end
    end
    for (int o = 0; o < 4; o++) begin
      if (out_load[o]) begin
        out_pkt_r[o] <= head_pkt[grant_idx[o]];
      end
    end
  end

endmodule

// ==== hw/mem_bank.sv ====
// word memory bank endpoint
`timescale 1ns/1ps

module mem_bank
  import mesh_pkg::*;
#(
  parameter int my_x = 0,
  parameter int my_y = NUM_Y + 1
) (
  input  logic      clk,
  input  logic      reset,

  input  link_pkt_s req_pkt_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,

  output link_pkt_s rsp_pkt_o,
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i
);

  logic [DATA_W-1:0] mem [MEM_WORDS];

  link_pkt_s rsp_pkt_r;
  logic      rsp_valid_r;
  link_pkt_s rsp_next;
  logic      req_fire;

  // one reply outstanding at a time
  assign req_ready_o = !rsp_valid_r;
  assign req_fire    = req_valid_i && req_ready_o;
  assign rsp_pkt_o   = rsp_pkt_r;
  assign rsp_valid_o = rsp_valid_r;

  always_comb begin
    rsp_next       = '0;
    rsp_next.op    = OP_REPLY;
    rsp_next.dst_x = req_pkt_i.src_x;
    rsp_next.dst_y = req_pkt_i.src_y;
    rsp_next.src_x = X_W'(my_x);
    rsp_next.src_y = Y_W'(my_y);
    rsp_next.tag   = req_pkt_i.tag;
    rsp_next.addr  = req_pkt_i.addr;
    // stores reply with zero data
    if (req_pkt_i.op == OP_LOAD) begin
      rsp_next.data = mem[req_pkt_i.addr];
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      rsp_valid_r <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_r <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_r <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      rsp_pkt_r <= rsp_next;
      if (req_pkt_i.op == OP_STORE) begin
        mem[req_pkt_i.addr] <= req_pkt_i.data;
      end
    end
  end

endmodule

// ==== hw/link_tieoff.sv ====
// mesh edge terminator
`timescale 1ns/1ps

module link_tieoff
  import mesh_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  input  link_pkt_s pkt_i,
  input  logic      valid_i,
  output logic      ready_o,

  output link_pkt_s pkt_o,
  output logic      valid_o,
  input  logic      ready_i,

  output logic      stray_o
);

  logic stray_r;

  // sink everything, source nothing
  assign ready_o = 1'b1;
  assign pkt_o   = '0;
  assign valid_o = 1'b0;
  assign stray_o = stray_r;

  // sticky until reset
  always_ff @(posedge clk) begin
    if (!reset) begin
      stray_r <= 1'b0;
    end else if (valid_i && ready_o) begin
      stray_r <= 1'b1;
    end
  end

endmodule

// ==== hw/mesh_top.sv ====
// mesh fabric top level
`timescale 1ns/1ps

module mesh_top
  import mesh_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  input  link_pkt_s io_req_i,
  input  logic      io_req_valid_i,
  output logic      io_req_ready_o,

  output link_pkt_s io_rsp_o,
  output logic      io_rsp_valid_o,
  input  logic      io_rsp_ready_i,

  output logic      stray_o
);

  // per-router link bundles, [column][router row]
  link_pkt_s [3:0] in_pkt    [NUM_X][NUM_Y];
  logic [3:0]      in_valid  [NUM_X][NUM_Y];
  logic [3:0]      in_ready  [NUM_X][NUM_Y];
  link_pkt_s [3:0] out_pkt   [NUM_X][NUM_Y];
  logic [3:0]      out_valid [NUM_X][NUM_Y];
  logic [3:0]      out_ready [NUM_X][NUM_Y];

  // edge flags, column 0 north is the io port
  logic [NUM_X-1:1] stray_n;
  logic [NUM_Y-1:0] stray_w;
  logic [NUM_Y-1:0] stray_e;

  assign stray_o = |{stray_n, stray_w, stray_e};

  for (genvar x = 0; x < NUM_X; x++) begin : g_col
    for (genvar y = 0; y < NUM_Y; y++) begin : g_row

      mesh_router #(
        .my_x(x),
        .my_y(y + 1)
      ) router_i (
        .clk        (clk),
        .reset      (reset),
        .in_pkt_i   (in_pkt[x][y]),
        .in_valid_i (in_valid[x][y]),
        .in_ready_o (in_ready[x][y]),
        .out_pkt_o  (out_pkt[x][y]),
        .out_valid_o(out_valid[x][y]),
        .out_ready_i(out_ready[x][y])
      );

      // north side
      if (y > 0) begin : g_n_link
        assign in_pkt[x][y][PORT_N]    = out_pkt[x][y-1][PORT_S];
        assign in_valid[x][y][PORT_N]  = out_valid[x][y-1][PORT_S];
        assign out_ready[x][y][PORT_N] = in_ready[x][y-1][PORT_S];
      end else if (x == 0) begin : g_n_io
        assign in_pkt[x][y][PORT_N]    = io_req_i;
        assign in_valid[x][y][PORT_N]  = io_req_valid_i;
        assign io_req_ready_o          = in_ready[x][y][PORT_N];
        assign io_rsp_o                = out_pkt[x][y][PORT_N];
        assign io_rsp_valid_o          = out_valid[x][y][PORT_N];
        assign out_ready[x][y][PORT_N] = io_rsp_ready_i;
      end else begin : g_n_tie
        link_tieoff tie_n_i (
          .clk    (clk),
          .reset  (reset),
          .pkt_i  (out_pkt[x][y][PORT_N]),
          .valid_i(out_valid[x][y][PORT_N]),
          .ready_o(out_ready[x][y][PORT_N]),
          .pkt_o  (in_pkt[x][y][PORT_N]),
          .valid_o(in_valid[x][y][PORT_N]),
          .ready_i(in_ready[x][y][PORT_N]),
          .stray_o(stray_n[x])
        );
      end

      // south side, bottom row feeds the memory banks
      if (y < NUM_Y - 1) begin : g_s_link
        assign in_pkt[x][y][PORT_S]    = out_pkt[x][y+1][PORT_N];
        assign in_valid[x][y][PORT_S]  = out_valid[x][y+1][PORT_N];
        assign out_ready[x][y][PORT_S] = in_ready[x][y+1][PORT_N];
      end else begin : g_s_mem
        mem_bank #(
          .my_x(x),
          .my_y(NUM_Y + 1)
        ) bank_i (
          .clk        (clk),
          .reset      (reset),
          .req_pkt_i  (out_pkt[x][y][PORT_S]),
          .req_valid_i(out_valid[x][y][PORT_S]),
          .req_ready_o(out_ready[x][y][PORT_S]),
          .rsp_pkt_o  (in_pkt[x][y][PORT_S]),
          .rsp_valid_o(in_valid[x][y][PORT_S]),
          .rsp_ready_i(in_ready[x][y][PORT_S])
        );
      end

      // east side
      if (x < NUM_X - 1) begin : g_e_link
        assign in_pkt[x][y][PORT_E]    = out_pkt[x+1][y][PORT_W];
        assign in_valid[x][y][PORT_E]  = out_valid[x+1][y][PORT_W];
        assign out_ready[x][y][PORT_E] = in_ready[x+1][y][PORT_W];
      end else begin : g_e_tie
        link_tieoff tie_e_i (
          .clk    (clk),
          .reset  (reset),
          .pkt_i  (out_pkt[x][y][PORT_E]),
          .valid_i(out_valid[x][y][PORT_E]),
          .ready_o(out_ready[x][y][PORT_E]),
          .pkt_o  (in_pkt[x][y][PORT_E]),
          .valid_o(in_valid[x][y][PORT_E]),
          .ready_i(in_ready[x][y][PORT_E]),
          .stray_o(stray_e[y])
        );
      end

      // west side
      if (x > 0) begin : g_w_link
        assign in_pkt[x][y][PORT_W]    = out_pkt[x-1][y][PORT_E];
        assign in_valid[x][y][PORT_W]  = out_valid[x-1][y][PORT_E];
        assign out_ready[x][y][PORT_W] = in_ready[x-1][y][PORT_E];
      end else begin : g_w_tie
        link_tieoff tie_w_i (
          .clk    (clk),
          .reset  (reset),
          .pkt_i  (out_pkt[x][y][PORT_W]),
          .valid_i(out_valid[x][y][PORT_W]),
          .ready_o(out_ready[x][y][PORT_W]),
          .pkt_o  (in_pkt[x][y][PORT_W]),
          .valid_o(in_valid[x][y][PORT_W]),
          .ready_i(in_ready[x][y][PORT_W]),
          .stray_o(stray_w[y])
        );
      end

    end
  end

endmodule

// ==== sim/tb_top.sv ====
// mesh fabric testbench
`timescale 1ns/1ps

module tb_top
  import mesh_pkg::*;
();

  localparam int SEED       = 42068;
  localparam int NUM_RANDOM = 300;
  localparam int WORST_LAT  = 60;
  // random phase at worst-case latency, plus directed and drain margin
  localparam int MAX_CYCLES = NUM_RANDOM * WORST_LAT + 2000;
  localparam int NUM_TAGS   = 1 << TAG_W;

  logic      clk = 1'b0;
  logic      reset;
  link_pkt_s io_req_i;
  logic      io_req_valid_i;
  logic      io_req_ready_o;
  link_pkt_s io_rsp_o;
  logic      io_rsp_valid_o;
  logic      io_rsp_ready_i;
  logic      stray_o;

  // reference model, owned by the stimulus process
  logic [DATA_W-1:0] ref_mem [NUM_X][MEM_WORDS];
  logic              written [NUM_X][MEM_WORDS];
  link_op_e          exp_op [NUM_TAGS];
  logic [DATA_W-1:0] exp_data [NUM_TAGS];
  int                exp_bank [NUM_TAGS];
  int                sent_cnt [NUM_TAGS];
  int                store_sent [NUM_X];
  logic [TAG_W-1:0]  next_tag;
  logic              stray_sent;
  int                err_seq;
  int                req_total;

  // reply side, owned by the monitor
  int   rsp_cnt [NUM_TAGS];
  int   store_done [NUM_X];
  int   rsp_total;
  int   err_mon;
  logic stray_seen;
  int   cycles = 0;

  mesh_top dut_i (
    .clk           (clk),
    .reset         (reset),
    .io_req_i      (io_req_i),
    .io_req_valid_i(io_req_valid_i),
    .io_req_ready_o(io_req_ready_o),
    .io_rsp_o      (io_rsp_o),
    .io_rsp_valid_o(io_rsp_valid_o),
    .io_rsp_ready_i(io_rsp_ready_i),
    .stray_o       (stray_o)
  );

  always #50 clk = ~clk;

  function automatic int outstanding();
    int n;
    n = 0;
    for (int t = 0; t < NUM_TAGS; t++) begin
      n += sent_cnt[t] - rsp_cnt[t];
    end
    return n;
  endfunction

  task automatic drive_rsp_ready();
    forever begin
      @(negedge clk);
      // low about 30 percent of cycles
      io_rsp_ready_i = ($urandom % 10) >= 3;
    end
  endtask

  task automatic drain();
    while (outstanding() != 0) begin
      @(negedge clk);
    end
  endtask

  // off-grid banks are sent but never expected back
  task automatic send_req(input link_op_e op, input int bank,
                          input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    link_pkt_s pkt;
    while (sent_cnt[next_tag] != rsp_cnt[next_tag]) begin
      @(negedge clk);
    end
    while (op == OP_LOAD && store_sent[bank] != store_done[bank]) begin
      @(negedge clk);
    end
    pkt       = '0;
    pkt.op    = op;
    pkt.dst_x = X_W'(bank);
    pkt.dst_y = Y_W'(NUM_Y + 1);
    pkt.tag   = next_tag;
    pkt.addr  = addr;
    pkt.data  = data;
    if (bank < NUM_X) begin
      exp_op[next_tag]   = op;
      exp_bank[next_tag] = bank;
      exp_data[next_tag] = (op == OP_LOAD) ? ref_mem[bank][addr] : '0;
      if (op == OP_STORE) begin
        ref_mem[bank][addr] = data;
        written[bank][addr] = 1'b1;
        store_sent[bank]++;
      end
      sent_cnt[next_tag]++;
      req_total++;
    end
    next_tag++;
    io_req_i       = pkt;
    io_req_valid_i = 1'b1;
    while (!io_req_ready_o) begin
      @(negedge clk);
    end
    @(negedge clk);
    io_req_valid_i = 1'b0;
  endtask

  // reply checker
  always @(posedge clk) begin
    logic [TAG_W-1:0] t;
    logic             known;
    if (!reset) begin
      for (int i = 0; i < NUM_TAGS; i++) begin
        rsp_cnt[i] = 0;
      end
      for (int b = 0; b < NUM_X; b++) begin
        store_done[b] = 0;
      end
      rsp_total  = 0;
      err_mon    = 0;
      stray_seen = 1'b0;
    end else begin
      if (stray_o) begin
        stray_seen = 1'b1;
      end
      assert (stray_sent || !stray_o) else begin
        err_mon++;
        $display("[FAIL] %0t: stray_o set before any off-grid request", $time);
      end
      assert (!stray_seen || stray_o) else begin
        err_mon++;
        $display("[FAIL] %0t: stray_o dropped after being set", $time);
      end
      if (io_rsp_valid_o && io_rsp_ready_i) begin
        t     = io_rsp_o.tag;
        known = sent_cnt[t] != rsp_cnt[t];
        // every accepted reply counts, expected or not
        rsp_total++;
        assert (known) else begin
          err_mon++;
          $display("[FAIL] %0t: reply with tag %0d not outstanding", $time, t);
        end
        if (known) begin
          assert (io_rsp_o.op == OP_REPLY && io_rsp_o.dst_x == '0 && io_rsp_o.dst_y == '0)
          else begin
            err_mon++;
            $display("[FAIL] %0t: tag %0d bad op or destination", $time, t);
          end
          assert (io_rsp_o.data === exp_data[t]) else begin
            err_mon++;
            $display("[FAIL] %0t: tag %0d data %h, expected %h", $time, t,
                     io_rsp_o.data, exp_data[t]);
          end
          assert (int'(io_rsp_o.src_x) == exp_bank[t] &&
                  int'(io_rsp_o.src_y) == NUM_Y + 1) else begin
            err_mon++;
            $display("[FAIL] %0t: tag %0d from (%0d,%0d), expected (%0d,%0d)", $time, t,
                     io_rsp_o.src_x, io_rsp_o.src_y, exp_bank[t], NUM_Y + 1);
          end
          if (exp_op[t] == OP_STORE) begin
            store_done[exp_bank[t]]++;
          end
          rsp_cnt[t]++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d requests still unanswered",
               cycles, outstanding());
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    int               bank;
    logic [ADDR_W-1:0] addr;
    void'($urandom(SEED));
    reset          = 1'b0;
    io_req_i       = '0;
    io_req_valid_i = 1'b0;
    io_rsp_ready_i = 1'b0;
    next_tag       = '0;
    stray_sent     = 1'b0;
    err_seq        = 0;
    req_total      = 0;
    for (int b = 0; b < NUM_X; b++) begin
      store_sent[b] = 0;
      for (int w = 0; w < MEM_WORDS; w++) begin
        written[b][w] = 1'b0;
      end
    end
    for (int t = 0; t < NUM_TAGS; t++) begin
      sent_cnt[t] = 0;
    end
    fork
      drive_rsp_ready();
    join_none
    repeat (8) @(negedge clk);
    reset = 1'b1;
    @(negedge clk);
    assert (!io_rsp_valid_o && !stray_o) else begin
      err_seq++;
      $display("[FAIL] %0t: reply valid or stray set right after reset", $time);
    end

    // same address in both banks
    send_req(OP_STORE, 0, 8'h05, 32'hcafe_0000);
    send_req(OP_STORE, 1, 8'h05, 32'hbeef_0001);
    send_req(OP_LOAD, 0, 8'h05, '0);
    send_req(OP_LOAD, 1, 8'h05, '0);
    drain();

    // off-grid column lands in the east tieoff
    stray_sent = 1'b1;
    send_req(OP_STORE, NUM_X, 8'h00, 32'h1234_5678);
    while (!stray_o) begin
      @(negedge clk);
    end
    repeat (40) @(negedge clk);
    assert (rsp_total == req_total) else begin
      err_seq++;
      $display("[FAIL] %0t: reply count %0d after off-grid request", $time, rsp_total);
    end

    for (int n = 0; n < NUM_RANDOM; n++) begin
      bank = int'($urandom % NUM_X);
      addr = ADDR_W'($urandom % 32);
      if (written[bank][addr] && ($urandom % 2 == 0)) begin
        send_req(OP_LOAD, bank, addr, '0);
      end else begin
        send_req(OP_STORE, bank, addr, $urandom);
      end
    end
    drain();
    assert (rsp_total == req_total && stray_o) else begin
      err_seq++;
      $display("[FAIL] %0t: %0d replies for %0d requests, stray %b", $time,
               rsp_total, req_total, stray_o);
    end

    $display("errors=%0d requests=%0d replies=%0d cycles=%0d",
             err_seq + err_mon, req_total, rsp_total, cycles);
    if (err_seq + err_mon == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
hw/mesh_pkg.sv
hw/mesh_router.sv
hw/mem_bank.sv
hw/link_tieoff.sv
hw/mesh_top.sv
sim/tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the mesh testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_top -Mdir obj_dir -f src.f \
  && ./obj_dir/Vtb_top | tee sim.log \
  || { echo "build or run failed"; exit 1; }
grep -qx "Regression passed" sim.log \
  && echo "simulation ok" \
  || { echo "simulation not ok, see sim.log"; exit 1; }
